// ==== Makefile ====
SIM        := verilator
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_mem_stage
FILELIST   := all.f
BUILD_DIR  := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
rtl/riscv_pkg.sv
rtl/mem_align.sv
rtl/lsu.sv
rtl/wb_data_ram.sv
rtl/mem_stage.sv
tests/tb_mem_stage.sv

// ==== rtl/lsu.sv ====
// load/store unit, pipelined wishbone B4 master with outstanding-transfer counter
`timescale 1ns/100ps

module lsu
    import riscv_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 2
)
(
    input  logic             clk_i,
    input  logic             rstn_i,

    // core side request, held while req_stall_o is high
    input  logic             req_i,
    input  logic             we_i,
    input  logic [XLEN-1:0]  addr_i,
    input  logic [SEL_W-1:0] wsel_byte_i,
    input  logic [XLEN-1:0]  wdata_i,

    // data port
    output wb_req_t          wb_req_o,
    input  wb_rsp_t          wb_rsp_i,

    output logic             issue_o,
    output logic             req_done_o,
    output logic [XLEN-1:0]  rdata_o,
    output logic             req_stall_o
);

    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

    typedef enum logic [1:0]
    {
        IDLE,
        BUS_REQ,
        BUS_WAIT
    } state_e;

    state_e           state_q;
    state_e           state_d;
    logic [CNT_W-1:0] outstanding_q;
    logic [CNT_W-1:0] outstanding_d;
    logic             full;
    logic             cyc;
    logic             stb;
    logic             accept;

    assign full    = (outstanding_q == CNT_W'(MAX_OUTSTANDING));
    assign accept  = stb && !wb_rsp_i.stall;
    assign issue_o = accept;

    // up on accept, down on ack
    always_comb
    begin
        outstanding_d = outstanding_q;
        if (accept && !wb_rsp_i.ack)
            outstanding_d = outstanding_q + 1'b1;
        else if (!accept && wb_rsp_i.ack)
            outstanding_d = outstanding_q - 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            state_q       <= IDLE;
            outstanding_q <= '0;
        end
        else
        begin
            state_q       <= state_d;
            outstanding_q <= outstanding_d;
        end
    end

    always_comb
    begin
        state_d     = state_q;
        req_stall_o = 1'b0;
        cyc         = 1'b0;
        stb         = 1'b0;

        case (state_q)
            IDLE:
            begin
                // hold the core for one cycle while the bus cycle opens
                if (req_i)
                begin
                    req_stall_o = 1'b1;
                    state_d     = BUS_REQ;
                end
            end

            BUS_REQ:
            begin
                cyc = 1'b1;
                stb = req_i && !full;

                if (req_i)
                    req_stall_o = full || wb_rsp_i.stall;
                else if (outstanding_d == '0)
                    state_d = IDLE;
                else
                    state_d = BUS_WAIT;
            end

            BUS_WAIT:
            begin
                cyc = 1'b1;

                if (req_i)
                begin
                    req_stall_o = 1'b1;
                    state_d     = BUS_REQ;
                end
                else if (outstanding_d == '0)
                begin
                    state_d = IDLE;
                end
            end

            default:
                state_d = IDLE;
        endcase
    end

    // request is translated combinationally while strobing
    always_comb
    begin
        wb_req_o      = '0;
        wb_req_o.cyc  = cyc;
        wb_req_o.stb  = stb;
        wb_req_o.lock = 1'b0;

        if (stb)
        begin
            wb_req_o.we    = we_i;
            wb_req_o.addr  = addr_i;
            wb_req_o.sel   = we_i ? wsel_byte_i : '1;
            wb_req_o.wdata = wdata_i;
        end
    end

    assign req_done_o = wb_rsp_i.ack;
    assign rdata_o    = wb_rsp_i.ack ? wb_rsp_i.rdata : '0;

endmodule

// ==== rtl/mem_align.sv ====
// store byte steering, byte-select generation and load data extraction with op queue
`timescale 1ns/100ps

module mem_align
    import riscv_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 2
)
(
    input  logic             clk_i,
    input  logic             rstn_i,

    // core side request
    input  mem_op_e          op_i,
    input  logic [XLEN-1:0]  addr_i,
    input  logic [XLEN-1:0]  wdata_i,

    // towards the lsu
    input  logic             issue_i,
    output logic             we_o,
    output logic [SEL_W-1:0] wsel_byte_o,
    output logic [XLEN-1:0]  wdata_o,

    // raw bus response from the lsu
    input  logic             ack_i,
    input  logic [XLEN-1:0]  bus_rdata_i,
    output logic [XLEN-1:0]  rdata_o
);

    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

    typedef struct packed
    {
        mem_op_e             op;
        logic [OFFSET_W-1:0] offset;
    } op_entry_t;

    op_entry_t           op_q [MAX_OUTSTANDING];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [OFFSET_W-1:0] offset;
    op_entry_t           head;
    logic [XLEN-1:0]     shifted;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == PTR_W'(MAX_OUTSTANDING - 1))
            nxt = '0;
        else
            nxt = ptr + 1'b1;
        return nxt;
    endfunction

    // store side, addresses are naturally aligned
    always_comb
    begin
        offset      = addr_i[OFFSET_W-1:0];
        we_o        = is_store(op_i);
        wsel_byte_o = '0;
        wdata_o     = '0;

        case (op_i)
            OP_SB:
            begin
                wsel_byte_o = SEL_W'(1) << offset;
                wdata_o     = {SEL_W{wdata_i[7:0]}};
            end
            OP_SH:
            begin
                wsel_byte_o = SEL_W'(3) << offset;
                wdata_o     = {(SEL_W / 2){wdata_i[15:0]}};
            end
            OP_SW:
            begin
                wsel_byte_o = '1;
                wdata_o     = wdata_i;
            end
            default:
            begin
                // loads, lsu forces all lanes on reads
            end
        endcase
    end

    // op queue pointers, one push per accepted transfer and one pop per ack
    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (issue_i)
                wr_ptr <= ptr_inc(wr_ptr);
            if (ack_i)
                rd_ptr <= ptr_inc(rd_ptr);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (issue_i)
            op_q[wr_ptr] <= '{op: op_i, offset: addr_i[OFFSET_W-1:0]};
    end

    // load side, pick the addressed lane and extend
    always_comb
    begin
        head    = op_q[rd_ptr];
        shifted = bus_rdata_i >> {head.offset, 3'b000};
        rdata_o = '0;

        if (ack_i)
        begin
            case (head.op)
                OP_LB:   rdata_o = {{(XLEN - 8){shifted[7]}}, shifted[7:0]};
                OP_LBU:  rdata_o = {{(XLEN - 8){1'b0}}, shifted[7:0]};
                OP_LH:   rdata_o = {{(XLEN - 16){shifted[15]}}, shifted[15:0]};
                OP_LHU:  rdata_o = {{(XLEN - 16){1'b0}}, shifted[15:0]};
                OP_LW:   rdata_o = bus_rdata_i;
                // stores return zero
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

// ==== rtl/mem_stage.sv ====
// memory stage top level joining alignment, load/store unit and data RAM
`timescale 1ns/100ps

module mem_stage
    import riscv_pkg::*;
#(
    parameter int MAX_OUTSTANDING = 2,
    parameter int RAM_WORDS       = 256,
    parameter int READ_LATENCY    = 2
)
(
    input  logic            clk_i,
    input  logic            rstn_i,

    input  logic            req_i,
    input  mem_op_e         op_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,

    output logic            stall_o,
    output logic            done_o,
    output logic [XLEN-1:0] rdata_o
);

    logic             we;
    logic [SEL_W-1:0] wsel_byte;
    logic [XLEN-1:0]  wdata_lane;
    logic             issue;
    logic [XLEN-1:0]  bus_rdata;
    wb_req_t          wb_req;
    wb_rsp_t          wb_rsp;

    mem_align #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_mem_align (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .issue_i     (issue),
        .we_o        (we),
        .wsel_byte_o (wsel_byte),
        .wdata_o     (wdata_lane),
        .ack_i       (done_o),
        .bus_rdata_i (bus_rdata),
        .rdata_o     (rdata_o)
    );

    lsu #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_lsu (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (req_i),
        .we_i        (we),
        .addr_i      (addr_i),
        .wsel_byte_i (wsel_byte),
        .wdata_i     (wdata_lane),
        .wb_req_o    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .issue_o     (issue),
        .req_done_o  (done_o),
        .rdata_o     (bus_rdata),
        .req_stall_o (stall_o)
    );

    wb_data_ram #(
        .RAM_WORDS    (RAM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_wb_data_ram (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

endmodule

// ==== rtl/riscv_pkg.sv ====
// data and address widths, memory opcode enum, wishbone request and response structs
package riscv_pkg;

    // data and address width
    parameter int XLEN = 32;

    // one byte select per byte lane
    parameter int SEL_W = XLEN / 8;

    // byte offset bits inside a word
    parameter int OFFSET_W = $clog2(SEL_W);

    // load and store opcodes seen by the memory stage
    typedef enum logic [2:0]
    {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } mem_op_e;

    // master to slave, pipelined wishbone B4
    typedef struct packed
    {
        logic             cyc;
        logic             stb;
        logic             lock;
        logic             we;
        logic [XLEN-1:0]  addr;
        logic [SEL_W-1:0] sel;
        logic [XLEN-1:0]  wdata;
    } wb_req_t;

    // slave to master
    typedef struct packed
    {
        logic            ack;
        logic            stall;
        logic [XLEN-1:0] rdata;
    } wb_rsp_t;

    // true for the three store widths
    function automatic logic is_store(input mem_op_e op);
        logic store;
        case (op)
            OP_SB, OP_SH, OP_SW:
                store = 1'b1;
            default:
                store = 1'b0;
        endcase
        return store;
    endfunction

endpackage

// ==== rtl/wb_data_ram.sv ====
// single-port pipelined wishbone slave RAM with byte writes and fixed ack latency
`timescale 1ns/100ps

module wb_data_ram
    import riscv_pkg::*;
#(
    parameter int RAM_WORDS    = 256,
    parameter int READ_LATENCY = 2
)
(
    input  logic    clk_i,
    input  logic    rstn_i,

    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int LAT_W = $clog2(READ_LATENCY + 1);

    logic [XLEN-1:0]  mem [RAM_WORDS];
    logic [LAT_W-1:0] count_q;
    logic [XLEN-1:0]  rdata_q;
    logic [IDX_W-1:0] word_idx;
    logic             ack;
    logic             stall;
    logic             accept;

    // word index sits above the byte offset
    assign word_idx = wb_req_i.addr[OFFSET_W +: IDX_W];

    // last countdown step is the ack cycle, a new transfer may be taken there
    assign ack    = (count_q == LAT_W'(1));
    assign stall  = (count_q != '0) && !ack;
    assign accept = wb_req_i.cyc && wb_req_i.stb && !stall;

    always_ff @(posedge clk_i)
    begin
        if (!rstn_i)
            count_q <= '0;
        else if (accept)
            count_q <= LAT_W'(READ_LATENCY);
        else if (count_q != '0)
            count_q <= count_q - 1'b1;
    end

    // byte lane writes
    always_ff @(posedge clk_i)
    begin
        if (accept && wb_req_i.we)
        begin
            for (int i = 0; i < SEL_W; i++)
            begin
                if (wb_req_i.sel[i])
                    mem[word_idx][8*i +: 8] <= wb_req_i.wdata[8*i +: 8];
            end
        end
    end

    // read data captured at accept and held until the ack
    always_ff @(posedge clk_i)
    begin
        if (accept && !wb_req_i.we)
            rdata_q <= mem[word_idx];
    end

    always_comb
    begin
        wb_rsp_o.ack   = ack;
        wb_rsp_o.stall = stall;
        wb_rsp_o.rdata = rdata_q;
    end

endmodule

// ==== tests/tb_mem_stage.sv ====
// testbench for mem_stage with stimulus table, byte-level memory model, lcg and done monitor
`timescale 1ns/100ps

module tb_mem_stage
    import riscv_pkg::*;
();

    localparam int READ_LATENCY = 2;
    localparam int TIMEOUT      = 200;

    typedef struct packed
    {
        mem_op_e         op;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            b2b;
    } stim_t;

    logic            clk_i;
    logic            rstn_i;
    logic            req_i;
    mem_op_e         op_i;
    logic [XLEN-1:0] addr_i;
    logic [XLEN-1:0] wdata_i;
    logic            stall_o;
    logic            done_o;
    logic [XLEN-1:0] rdata_o;

    stim_t           stim_tab [$];
    logic [XLEN-1:0] exp_q [$];
    logic [7:0]      model_mem [1024];
    logic [31:0]     lcg_state = 32'hd988e419;
    int              cycle_cnt = 0;
    int              accept_edge = 0;
    int              last_done_edge = 0;

    mem_stage DUT (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .req_i   (req_i),
        .op_i    (op_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .stall_o (stall_o),
        .done_o  (done_o),
        .rdata_o (rdata_o)
    );

    initial clk_i = 1'b0;
    always #2 clk_i = ~clk_i;

    always @(posedge clk_i)
        cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
    endtask

    // little-endian byte model, stores update it and loads return the extended value
    function automatic logic [31:0] model_access(input mem_op_e op, input logic [31:0] addr,
                                                 input logic [31:0] wdata);
        logic [9:0]  a;
        logic [31:0] res;
        a   = addr[9:0];
        res = '0;
        case (op)
            OP_SB:
                model_mem[a] = wdata[7:0];
            OP_SH:
            begin
                model_mem[a]         = wdata[7:0];
                model_mem[a + 10'd1] = wdata[15:8];
            end
            OP_SW:
            begin
                for (int i = 0; i < 4; i++)
                    model_mem[a + 10'(i)] = wdata[8*i +: 8];
            end
            OP_LB:
                res = {{24{model_mem[a][7]}}, model_mem[a]};
            OP_LBU:
                res = {24'd0, model_mem[a]};
            OP_LH:
                res = {{16{model_mem[a + 10'd1][7]}}, model_mem[a + 10'd1], model_mem[a]};
            OP_LHU:
                res = {16'd0, model_mem[a + 10'd1], model_mem[a]};
            default:
                res = {model_mem[a + 10'd3], model_mem[a + 10'd2],
                       model_mem[a + 10'd1], model_mem[a]};
        endcase
        return res;
    endfunction

    task automatic add_entry(input mem_op_e op, input logic [31:0] addr, input logic b2b);
        stim_tab.push_back('{op, addr, lcg_next(), b2b});
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [1:0]  off;
        mem_op_e     rop;
        // full words first so every later load sees known data
        for (int w = 0; w < 16; w++)
            add_entry(OP_SW, 32'(w * 4), 1'b0);
        for (int w = 0; w < 16; w++)
            add_entry(OP_LW, 32'(w * 4), 1'b0);
        // partial stores, each followed by a word read of the same word
        for (int o = 0; o < 4; o++)
        begin
            add_entry(OP_SB, 32'(4 + o), 1'b0);
            add_entry(OP_LW, 32'd4, 1'b0);
        end
        for (int o = 0; o < 4; o += 2)
        begin
            add_entry(OP_SH, 32'(8 + o), 1'b0);
            add_entry(OP_LW, 32'd8, 1'b0);
        end
        // sub-word loads at every valid offset
        for (int w = 3; w < 7; w++)
        begin
            for (int o = 0; o < 4; o++)
            begin
                add_entry(OP_LB, 32'(w * 4 + o), 1'b0);
                add_entry(OP_LBU, 32'(w * 4 + o), 1'b0);
                if (o % 2 == 0)
                begin
                    add_entry(OP_LH, 32'(w * 4 + o), 1'b0);
                    add_entry(OP_LHU, 32'(w * 4 + o), 1'b0);
                end
            end
        end
        // random mix issued back to back
        for (int n = 0; n < 24; n++)
        begin
            r   = lcg_next();
            rop = mem_op_e'(r[2:0]);
            off = r[9:8];
            if (rop == OP_LH || rop == OP_LHU || rop == OP_SH)
                off[0] = 1'b0;
            else if (rop == OP_LW || rop == OP_SW)
                off = 2'd0;
            add_entry(rop, {26'd0, r[6:3], off}, 1'b1);
        end
        // single load from idle for the latency check
        add_entry(OP_LW, 32'd0, 1'b0);
    endtask

    // called at the drive point, returns at the drive point after the accepting edge
    task automatic apply_entry(input stim_t e);
        int waited;
        waited  = 0;
        req_i   = 1'b1;
        op_i    = e.op;
        addr_i  = e.addr;
        wdata_i = e.wdata;
        @(negedge clk_i);
        while (stall_o)
        begin
            waited++;
            if (waited > TIMEOUT)
                stop_with_failure("timeout: stall_o never dropped for a pending request");
            @(negedge clk_i);
        end
        accept_edge = cycle_cnt + 1;
        exp_q.push_back(model_access(e.op, e.addr, e.wdata));
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            waited++;
            if (waited > TIMEOUT)
                stop_with_failure("timeout: done_o missing for an accepted request");
            @(posedge clk_i);
            #1;
        end
    endtask

    // every done pulse must match the oldest outstanding request
    always @(negedge clk_i)
    begin : done_monitor
        logic [31:0] exp;
        if (rstn_i && done_o)
        begin
            if (exp_q.size() == 0)
                stop_with_failure("done_o pulsed with no request outstanding");
            exp = exp_q.pop_front();
            check_value("rdata_o", rdata_o, exp);
            last_done_edge = cycle_cnt + 1;
        end
    end

    initial
    begin
        rstn_i  = 1'b0;
        req_i   = 1'b0;
        op_i    = OP_LW;
        addr_i  = '0;
        wdata_i = '0;
        build_table();
        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // quiet bus after reset
        repeat (10)
        begin
            @(negedge clk_i);
            check_value("stall_o", 32'(stall_o), 32'd0);
            check_value("done_o", 32'(done_o), 32'd0);
        end
        @(posedge clk_i);
        #1;

        foreach (stim_tab[i])
        begin
            if (!stim_tab[i].b2b)
            begin
                req_i = 1'b0;
                wait_drain();
            end
            apply_entry(stim_tab[i]);
        end
        req_i = 1'b0;
        wait_drain();

        check_value("done_latency", 32'(last_done_edge - accept_edge), 32'(READ_LATENCY));

        if (exp_q.size() == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            stop_with_failure("expected results left over at the end of the run");
        end
    end

endmodule
